// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = coll_reduce_tb
FILELIST = build.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// File: build.f
logic/coll_pkg.sv
logic/flit_fifo.sv
logic/reduce_table.sv
logic/coll_apb_regs.sv
logic/coll_reduce_top.sv
verification/coll_reduce_tb.sv

// File: logic/coll_apb_regs.sv
module coll_apb_regs (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [coll_pkg::ADDR_W-1:0]  paddr,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [31:0]                  pwdata,
  output logic [31:0]                  prdata,
  output logic                         pready,
  output logic                         pslverr,
  output logic                         enable,
  output logic [coll_pkg::CHILD_W-1:0] children,
  input  logic                         done_pulse,
  input  logic                         drop_pulse
);

  import coll_pkg::*;

  logic             access;
  logic             addr_ok;
  logic [CNT_W-1:0] done_cnt;
  logic [CNT_W-1:0] drop_cnt;

  // access phase of an apb transfer, never stretched
  assign access = psel && penable;
  assign pready = 1'b1;

  assign addr_ok = (paddr == ADDR_CTRL) || (paddr == ADDR_DONE) || (paddr == ADDR_DROP);

  // unknown address, or a write to one of the counters
  assign pslverr = access && (!addr_ok || (pwrite && paddr != ADDR_CTRL));

  // read mux
  always_comb
  begin
    case (paddr)
      ADDR_CTRL: prdata = {{(31 - CHILD_W){1'b0}}, children, enable};
      ADDR_DONE: prdata = {{(32 - CNT_W){1'b0}}, done_cnt};
      ADDR_DROP: prdata = {{(32 - CNT_W){1'b0}}, drop_cnt};
      default:   prdata = '0;
    endcase
  end

  // ctrl: bit 0 enable, children count right above it
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      enable   <= 1'b0;
      children <= '0;
    end
    else if (access && pwrite && paddr == ADDR_CTRL)
    begin
      enable   <= pwdata[0];
      children <= pwdata[CHILD_W:1];
    end
  end

  // status counters stick at all ones
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      done_cnt <= '0;
      drop_cnt <= '0;
    end
    else
    begin
      if (done_pulse && done_cnt != '1)
        done_cnt <= done_cnt + 1'b1;
      if (drop_pulse && drop_cnt != '1)
        drop_cnt <= drop_cnt + 1'b1;
    end
  end

endmodule

// File: logic/coll_pkg.sv
package coll_pkg;

  // field widths of the flit, kept in one place
  localparam int PAYLOAD_W = 32;
  localparam int OP_W      = 4;
  localparam int ALG_W     = 2;
  localparam int TAG_W     = 8;
  localparam int CTX_W     = 8;
  localparam int RANK_W    = 9;
  localparam int COORD_W   = 3;

  // configuration and status widths
  localparam int CHILD_W   = 3;
  localparam int CNT_W     = 16;
  localparam int ADDR_W    = 8;

  // storage sizes
  localparam int TABLE_SIZE   = 6;
  localparam int TBL_IDX_W    = $clog2(TABLE_SIZE);
  localparam int FLIT_DEPTH   = 16;
  localparam int RESULT_DEPTH = 4;

  // apb register map
  localparam logic [ADDR_W-1:0] ADDR_CTRL = 8'h00;
  localparam logic [ADDR_W-1:0] ADDR_DONE = 8'h04;
  localparam logic [ADDR_W-1:0] ADDR_DROP = 8'h08;

  // reduction ops, max and min compare unsigned
  typedef enum logic [OP_W-1:0] {
    OP_SUM = 4'd0,
    OP_MAX = 4'd1,
    OP_MIN = 4'd2,
    OP_XOR = 4'd3
  } op_t;

  // one mesh coordinate, z in the top bits
  typedef struct packed {
    logic [COORD_W-1:0] z;
    logic [COORD_W-1:0] y;
    logic [COORD_W-1:0] x;
  } xyz_t;

  // 82 bit network flit, valid at bit 81 down to payload at bit 0
  // op is raw so that illegal codes can still be seen and dropped
  typedef struct packed {
    logic                 valid;
    xyz_t                 dst;
    xyz_t                 src;
    logic [RANK_W-1:0]    rank;
    logic [CTX_W-1:0]     context_id;
    logic [TAG_W-1:0]     tag;
    logic [ALG_W-1:0]     alg_type;
    logic [OP_W-1:0]      op;
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

  // finished reduction, 52 bits
  typedef struct packed {
    logic [CTX_W-1:0]     context_id;
    logic [TAG_W-1:0]     tag;
    op_t                  op;
    logic [PAYLOAD_W-1:0] payload;
  } result_t;

endpackage

// File: logic/coll_reduce_top.sv
module coll_reduce_top (
  input  logic                           clk,
  input  logic                           rst,
  // flit input
  input  coll_pkg::flit_t                flit_in,
  input  logic                           flit_push,
  output logic                           flit_full,
  // result output
  output logic [coll_pkg::CTX_W-1:0]     res_context_id,
  output logic [coll_pkg::TAG_W-1:0]     res_tag,
  output logic [coll_pkg::OP_W-1:0]      res_op,
  output logic [coll_pkg::PAYLOAD_W-1:0] res_payload,
  output logic                           res_valid,
  input  logic                           res_ready,
  // apb
  input  logic [coll_pkg::ADDR_W-1:0]    paddr,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [31:0]                    pwdata,
  output logic [31:0]                    prdata,
  output logic                           pready,
  output logic                           pslverr
);

  import coll_pkg::*;

  flit_t              head_flit;
  logic               flit_empty;
  logic               tbl_pop;
  result_t            tbl_res;
  logic               tbl_res_push;
  logic               res_full;
  result_t            res_head;
  logic               res_empty;
  logic               enable;
  logic [CHILD_W-1:0] children;
  logic               done_pulse;
  logic               drop_pulse;

  // incoming flits wait here until the table takes them
  flit_fifo #(.item_t(flit_t), .DEPTH(FLIT_DEPTH)) i_flit_fifo (
    .clk(clk), .rst(rst), .wr_data(flit_in), .wr_en(flit_push), .rd_en(tbl_pop),
    .rd_data(head_flit), .empty(flit_empty), .full(flit_full));

  reduce_table i_table (
    .clk(clk), .rst(rst), .enable(enable), .children(children),
    .head(head_flit), .head_valid(!flit_empty), .pop(tbl_pop),
    .res_data(tbl_res), .res_push(tbl_res_push), .res_full(res_full),
    .done_pulse(done_pulse), .drop_pulse(drop_pulse));

  // finished reductions, drained by a valid/ready handshake
  flit_fifo #(.item_t(result_t), .DEPTH(RESULT_DEPTH)) i_result_fifo (
    .clk(clk), .rst(rst), .wr_data(tbl_res), .wr_en(tbl_res_push),
    .rd_en(res_valid && res_ready), .rd_data(res_head), .empty(res_empty),
    .full(res_full));

  assign res_valid      = !res_empty;
  assign res_context_id = res_head.context_id;
  assign res_tag        = res_head.tag;
  assign res_op         = res_head.op;
  assign res_payload    = res_head.payload;

  coll_apb_regs i_regs (
    .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .enable(enable), .children(children),
    .done_pulse(done_pulse), .drop_pulse(drop_pulse));

endmodule

// File: logic/flit_fifo.sv
module flit_fifo #(
  parameter type item_t = coll_pkg::flit_t,
  parameter int  DEPTH  = 16
) (
  input  logic  clk,
  input  logic  rst,
  input  item_t wr_data,
  input  logic  wr_en,
  input  logic  rd_en,
  output item_t rd_data,
  output logic  empty,
  output logic  full
);

  // pointer and occupancy widths follow the depth
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int OCC_W = $clog2(DEPTH + 1);

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [OCC_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  // wrap at depth, also for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  // a push when full and a pop when empty are both ignored
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // flags come straight off the registered count
  assign empty = (count == '0);
  assign full  = (count == OCC_W'(DEPTH));

  // show-ahead: head entry is always on the output
  assign rd_data = mem[rd_ptr];

  // storage
  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr_data;
  end

  // pointers
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= next_ptr(wr_ptr);
      if (do_rd)
        rd_ptr <= next_ptr(rd_ptr);
    end
  end

  // occupancy, push and pop together leave it unchanged
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      count <= '0;
    else
    begin
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // occupancy stays within the storage
  a_count_bound: assert property (@(posedge clk) disable iff (rst)
    count <= OCC_W'(DEPTH));

  // the consumer never reads an empty fifo
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    !(rd_en && empty));

endmodule

// File: logic/reduce_table.sv
module reduce_table (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         enable,
  input  logic [coll_pkg::CHILD_W-1:0] children,
  input  coll_pkg::flit_t              head,
  input  logic                         head_valid,
  output logic                         pop,
  output coll_pkg::result_t            res_data,
  output logic                         res_push,
  input  logic                         res_full,
  output logic                         done_pulse,
  output logic                         drop_pulse
);

  import coll_pkg::*;

  // entry state, only the valid bits are control
  logic [TABLE_SIZE-1:0] ent_valid;
  logic [CTX_W-1:0]      ent_ctx [TABLE_SIZE];
  logic [TAG_W-1:0]      ent_tag [TABLE_SIZE];
  op_t                   ent_op  [TABLE_SIZE];
  logic [PAYLOAD_W-1:0]  ent_acc [TABLE_SIZE];
  logic [CHILD_W-1:0]    ent_cnt [TABLE_SIZE];

  logic                  bad;
  logic                  leaf;
  logic                  hit;
  logic [TBL_IDX_W-1:0]  hit_idx;
  logic                  any_free;
  logic [TBL_IDX_W-1:0]  free_idx;
  logic                  completes;
  logic                  can_accept;
  logic                  accept_good;
  logic [PAYLOAD_W-1:0]  combined;
  logic                  key_dup;

  // one cycle integer combine, the op of the entry governs
  function automatic logic [PAYLOAD_W-1:0] combine(
    input op_t                  op,
    input logic [PAYLOAD_W-1:0] a,
    input logic [PAYLOAD_W-1:0] b
  );
    case (op)
      OP_SUM:  return a + b;
      OP_MAX:  return (a > b) ? a : b;
      OP_MIN:  return (a < b) ? a : b;
      default: return a ^ b;
    endcase
  endfunction

  // invalid flits and unknown ops are consumed and counted only
  assign bad  = !head.valid || !(head.op inside {OP_SUM, OP_MAX, OP_MIN, OP_XOR});
  assign leaf = (children == '0);

  // key lookup and lowest free slot
  // scanning downwards leaves the lowest index in the result
  always_comb
  begin
    hit      = 1'b0;
    hit_idx  = '0;
    any_free = 1'b0;
    free_idx = '0;
    for (int i = TABLE_SIZE - 1; i >= 0; i--)
    begin
      if (ent_valid[i] && ent_ctx[i] == head.context_id && ent_tag[i] == head.tag)
      begin
        hit     = 1'b1;
        hit_idx = TBL_IDX_W'(i);
      end
      if (!ent_valid[i])
      begin
        any_free = 1'b1;
        free_idx = TBL_IDX_W'(i);
      end
    end
  end

  assign combined = combine(ent_op[hit_idx], ent_acc[hit_idx], head.payload);

  // an open entry finishes on the children-th extra contribution
  // without an entry only a leaf completes at once
  assign completes = !bad && (hit ? (ent_cnt[hit_idx] >= children) : leaf);

  // completing needs room downstream, opening needs a free entry
  always_comb
  begin
    if (bad)
      can_accept = 1'b1;
    else if (completes)
      can_accept = !res_full;
    else
      can_accept = hit || any_free;
  end

  assign pop         = enable && head_valid && can_accept;
  assign accept_good = pop && !bad;

  // result goes out on the same edge the last flit is taken
  assign res_push            = pop && completes;
  assign res_data.context_id = head.context_id;
  assign res_data.tag        = head.tag;
  assign res_data.op         = hit ? ent_op[hit_idx] : op_t'(head.op);
  assign res_data.payload    = hit ? combined : head.payload;

  assign done_pulse = res_push;
  assign drop_pulse = pop && bad;

  // entry occupancy
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      ent_valid <= '0;
    else if (accept_good)
    begin
      if (hit && completes)
        ent_valid[hit_idx] <= 1'b0;
      else if (!hit && !leaf)
        ent_valid[free_idx] <= 1'b1;
    end
  end

  // entry contents, a freed slot keeps stale data
  always_ff @(posedge clk)
  begin
    if (accept_good)
    begin
      if (hit)
      begin
        ent_acc[hit_idx] <= combined;
        ent_cnt[hit_idx] <= ent_cnt[hit_idx] + 1'b1;
      end
      else if (!leaf)
      begin
        ent_ctx[free_idx] <= head.context_id;
        ent_tag[free_idx] <= head.tag;
        ent_op[free_idx]  <= op_t'(head.op);
        ent_acc[free_idx] <= head.payload;
        ent_cnt[free_idx] <= CHILD_W'(1);
      end
    end
  end

  // pairwise key compare over the open entries
  always_comb
  begin
    key_dup = 1'b0;
    for (int i = 0; i < TABLE_SIZE; i++)
      for (int j = i + 1; j < TABLE_SIZE; j++)
        if (ent_valid[i] && ent_valid[j] &&
            ent_ctx[i] == ent_ctx[j] && ent_tag[i] == ent_tag[j])
          key_dup = 1'b1;
  end

  // a key lives in at most one entry
  a_unique_keys: assert property (@(posedge clk) disable iff (rst) !key_dup);

  // only the fifo head is ever consumed
  a_pop_needs_head: assert property (@(posedge clk) disable iff (rst)
    pop |-> head_valid);

endmodule

// File: verification/coll_reduce_tb.sv
module coll_reduce_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import coll_pkg::*;

  // run length bound and handshake wait limit
  localparam int NUM_TESTS     = 6;
  localparam int TEST_BOUND_NS = 2000;
  localparam int WAIT_CYCLES   = 200;

  logic                 clk;
  logic                 rst;
  flit_t                flit_in;
  logic                 flit_push;
  logic                 flit_full;
  logic [CTX_W-1:0]     res_context_id;
  logic [TAG_W-1:0]     res_tag;
  logic [OP_W-1:0]      res_op;
  logic [PAYLOAD_W-1:0] res_payload;
  logic                 res_valid;
  logic                 res_ready;
  logic [ADDR_W-1:0]    paddr;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [31:0]          pwdata;
  logic [31:0]          prdata;
  logic                 pready;
  logic                 pslverr;

  int                   errors;
  int                   checks;
  integer               seed;
  result_t              exp_q [$];
  // first payload of each open key in the back-pressure test
  logic [31:0]          open_payload [16];

  coll_reduce_top i_dut (
    .clk(clk), .rst(rst), .flit_in(flit_in), .flit_push(flit_push), .flit_full(flit_full),
    .res_context_id(res_context_id), .res_tag(res_tag), .res_op(res_op),
    .res_payload(res_payload), .res_valid(res_valid), .res_ready(res_ready),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr));

  // 4 ns clock
  always #2 clk = ~clk;

  task automatic check_result(input string name, input result_t want, input result_t got);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("Fail at %0t: %s expected %h got %h", $time, name, want, got);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] want, input logic [31:0] got);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("Fail at %0t: %s expected %h got %h", $time, name, want, got);
    end
  endtask

  task automatic check_bit(input string name, input logic want, input logic got);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("Fail at %0t: %s expected %b got %b", $time, name, want, got);
    end
  endtask

  // sum, unsigned max, unsigned min or xor by op code
  function automatic logic [31:0] reduce_ref(input logic [3:0] op, input logic [31:0] acc,
                                             input logic [31:0] val);
    case (op)
      4'd0:    return acc + val;
      4'd1:    return (val > acc) ? val : acc;
      4'd2:    return (val < acc) ? val : acc;
      default: return acc ^ val;
    endcase
  endfunction

  function automatic flit_t make_flit(input logic valid, input logic [CTX_W-1:0] ctx,
                                      input logic [TAG_W-1:0] tag, input logic [OP_W-1:0] op,
                                      input logic [PAYLOAD_W-1:0] payload);
    flit_t f;
    f            = '0;
    f.valid      = valid;
    f.rank       = RANK_W'(tag);
    f.context_id = ctx;
    f.tag        = tag;
    f.op         = op;
    f.payload    = payload;
    return f;
  endfunction

  task automatic expect_result(input logic [CTX_W-1:0] ctx, input logic [TAG_W-1:0] tag,
                               input logic [OP_W-1:0] op, input logic [31:0] payload);
    result_t r;
    r.context_id = ctx;
    r.tag        = tag;
    r.op         = op_t'(op);
    r.payload    = payload;
    exp_q.push_back(r);
  endtask

  // setup phase then access phase with responses sampled mid low phase
  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic exp_err);
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b1;
    pwdata  = data;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    check_bit("pready", 1'b1, pready);
    check_bit("pslverr", exp_err, pslverr);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, input logic exp_err,
                          output logic [31:0] data);
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    check_bit("pslverr", exp_err, pslverr);
    data = prdata;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // flit_full only moves on rising edges so a low sample holds for the push
  task automatic push_flit(input flit_t f);
    @(negedge clk);
    while (flit_full)
      @(negedge clk);
    flit_in   = f;
    flit_push = 1'b1;
    @(negedge clk);
    flit_push = 1'b0;
  endtask

  task automatic pop_result();
    result_t want;
    result_t got;
    int      waited;
    want   = exp_q.pop_front();
    waited = 0;
    @(negedge clk);
    while (!res_valid && waited < WAIT_CYCLES)
    begin
      @(negedge clk);
      waited++;
    end
    if (!res_valid)
    begin
      errors++;
      $display("no result arrived within %0d cycles at %0t", WAIT_CYCLES, $time);
    end
    else
    begin
      got.context_id = res_context_id;
      got.tag        = res_tag;
      got.op         = op_t'(res_op);
      got.payload    = res_payload;
      check_result("result", want, got);
      res_ready = 1'b1;
      @(negedge clk);
      res_ready = 1'b0;
    end
  endtask

  task automatic drain_results();
    while (exp_q.size() > 0)
      pop_result();
    check_bit("res_valid", 1'b0, res_valid);
  endtask

  task automatic test_registers();
    logic [31:0] rd;
    check_bit("flit_full", 1'b0, flit_full);
    check_bit("res_valid", 1'b0, res_valid);
    apb_read(ADDR_CTRL, 1'b0, rd);
    check_word("ctrl", 32'h0, rd);
    // enable with five children
    apb_write(ADDR_CTRL, 32'hB, 1'b0);
    apb_read(ADDR_CTRL, 1'b0, rd);
    check_word("ctrl", 32'hB, rd);
    apb_write(ADDR_DONE, 32'h1, 1'b1);
    apb_write(8'h0C, 32'h1, 1'b1);
    apb_read(8'h10, 1'b1, rd);
    apb_read(ADDR_DONE, 1'b0, rd);
    check_word("done count", 32'h0, rd);
    apb_write(ADDR_CTRL, 32'h0, 1'b0);
  endtask

  task automatic test_leaf();
    logic [31:0] base;
    logic [31:0] rd;
    flit_t       f;
    apb_write(ADDR_CTRL, 32'h1, 1'b0);
    apb_read(ADDR_DONE, 1'b0, base);
    for (int i = 0; i < 5; i++)
    begin
      f = make_flit(1'b1, 8'(8'h20 + i), 8'(i), OP_SUM, $random(seed));
      push_flit(f);
      expect_result(f.context_id, f.tag, f.op, f.payload);
    end
    drain_results();
    apb_read(ADDR_DONE, 1'b0, rd);
    check_word("done count", base + 32'd5, rd);
  endtask

  // four keys over two contexts and two tags
  // interleaved round by round and later flits carry another op
  task automatic test_combine();
    flit_t       f;
    logic [31:0] acc [4];
    logic [3:0]  op;
    apb_write(ADDR_CTRL, 32'h5, 1'b0);
    for (int r = 0; r < 3; r++)
      for (int k = 0; k < 4; k++)
      begin
        op = (r == 0) ? 4'(k) : 4'((k + r) % 4);
        f  = make_flit(1'b1, 8'(8'h40 + k / 2), 8'(8'h80 + k % 2), op, $random(seed));
        push_flit(f);
        acc[k] = (r == 0) ? f.payload : reduce_ref(4'(k), acc[k], f.payload);
      end
    for (int k = 0; k < 4; k++)
      expect_result(8'(8'h40 + k / 2), 8'(8'h80 + k % 2), 4'(k), acc[k]);
    drain_results();
  endtask

  task automatic test_drops();
    logic [31:0] base;
    logic [31:0] rd;
    int          polls;
    // in leaf mode a kept flit would show up as a result
    apb_write(ADDR_CTRL, 32'h1, 1'b0);
    apb_read(ADDR_DROP, 1'b0, base);
    push_flit(make_flit(1'b0, 8'h50, 8'h01, OP_SUM, $random(seed)));
    push_flit(make_flit(1'b1, 8'h51, 8'h02, 4'd9, $random(seed)));
    polls = 0;
    rd    = base;
    while (rd != base + 32'd2 && polls < WAIT_CYCLES)
    begin
      apb_read(ADDR_DROP, 1'b0, rd);
      polls++;
    end
    check_word("drop count", base + 32'd2, rd);
    check_bit("res_valid", 1'b0, res_valid);
  endtask

  // opens or closes key k with one child configured
  task automatic key_flit(input int k, input logic closing);
    flit_t f;
    f = make_flit(1'b1, 8'(8'h60 + k), 8'h07, 4'(k % 4), $random(seed));
    push_flit(f);
    if (!closing)
      open_payload[k] = f.payload;
    else
      expect_result(f.context_id, f.tag, f.op, reduce_ref(f.op, open_payload[k], f.payload));
  endtask

  // with res_ready low four results fill the result fifo
  // and the sixteen flits behind them fill the flit fifo
  task automatic test_backpressure();
    apb_write(ADDR_CTRL, 32'h3, 1'b0);
    for (int k = 0; k < 6; k++)
      key_flit(k, 1'b0);
    for (int k = 0; k < 6; k++)
      key_flit(k, 1'b1);
    for (int k = 6; k < 13; k++)
    begin
      key_flit(k, 1'b0);
      key_flit(k, 1'b1);
    end
    check_bit("flit_full", 1'b1, flit_full);
    check_bit("res_valid", 1'b1, res_valid);
    drain_results();
    check_bit("flit_full", 1'b0, flit_full);
  endtask

  task automatic test_disable();
    flit_t f;
    apb_write(ADDR_CTRL, 32'h0, 1'b0);
    for (int i = 0; i < 3; i++)
    begin
      f = make_flit(1'b1, 8'(8'h70 + i), 8'(i), OP_XOR, $random(seed));
      push_flit(f);
      expect_result(f.context_id, f.tag, f.op, f.payload);
    end
    // nothing may come out while disabled
    repeat (20) @(negedge clk);
    check_bit("res_valid", 1'b0, res_valid);
    apb_write(ADDR_CTRL, 32'h1, 1'b0);
    drain_results();
  endtask

  initial
  begin
    clk       = 1'b0;
    rst       = 1'b1;
    flit_in   = '0;
    flit_push = 1'b0;
    res_ready = 1'b0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    errors    = 0;
    checks    = 0;
    seed      = 36379;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_registers();
    test_leaf();
    test_combine();
    test_drops();
    test_backpressure();
    test_disable();
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(NUM_TESTS * TEST_BOUND_NS);
    $display("timeout: run did not finish within %0d ns", NUM_TESTS * TEST_BOUND_NS);
    $display("checks: %0d errors: %0d", checks, errors);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
